/* Bender.yml */
package:
  name: fetchCache

sources:
  - include_dirs:
      - src
    files:
      - src/fetchCachePkg.sv
      - src/cacheWayArray.sv
      - src/refillController.sv
      - src/missLatencyTimer.sv
      - src/accessStats.sv
      - src/mainMemory.sv
      - src/fetchCache.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - tb/fetchCache_chk.sv
      - tb/fetchCacheTb.sv

/* fetchCache.f */
+incdir+src
src/fetchCachePkg.sv
src/cacheWayArray.sv
src/refillController.sv
src/missLatencyTimer.sv
src/accessStats.sv
src/mainMemory.sv
src/fetchCache.sv
tb/fetchCache_chk.sv
tb/fetchCacheTb.sv

/* src/accessStats.sv */
// Cache hit and miss counters
`timescale 1ns/1ps

module accessStats (
        input  logic                     CLK,
        input  logic                     RESET,
        input  logic                     countHit,
        input  logic                     countMiss,
        output fetchCachePkg::statCountT hitCount,
        output fetchCachePkg::statCountT missCount
);

        // Both counters wrap at overflow
        always_ff @(posedge CLK or posedge RESET) begin
                if (RESET) begin
                        hitCount  <= '0;
                        missCount <= '0;
                end else begin
                        if (countHit) begin
                                hitCount <= hitCount + 1'b1;
                        end
                        if (countMiss) begin
                                missCount <= missCount + 1'b1;
                        end
                end
        end

endmodule

/* src/cacheWayArray.sv */
// Two-way tag, valid, data and recent bit storage with lookup and refill write
`timescale 1ns/1ps
`include "fetchCache_config.svh"

module cacheWayArray (
        input  logic               CLK,
        input  logic               RESET,
        input  fetchCachePkg::tagT  curTag,
        input  fetchCachePkg::setT  curSet,
        input  logic               touch,
        input  logic               refill,
        input  fetchCachePkg::wordT refillData,
        output logic               lookupHit,
        output fetchCachePkg::wordT lookupData
);
        import fetchCachePkg::*;

        tagT  tagMem  [2][`FC_SETS];
        wordT dataMem [2][`FC_SETS];

        logic [`FC_SETS-1:0] validBits [2];
        logic [`FC_SETS-1:0] recentWay;    // Index of the recently used way, per set

        logic hit0;
        logic hit1;
        logic hitWay;
        logic victimWay;

        // A matching tag only counts with its valid bit set
        assign hit0 = validBits[0][curSet] && (tagMem[0][curSet] == curTag);
        assign hit1 = validBits[1][curSet] && (tagMem[1][curSet] == curTag);

        assign lookupHit  = hit0 || hit1;
        assign hitWay     = hit1;
        assign lookupData = dataMem[hitWay][curSet];

        // Empty ways fill first, way 0 before way 1
        always_comb begin
                if (!validBits[0][curSet]) begin
                        victimWay = 1'b0;
                end else if (!validBits[1][curSet]) begin
                        victimWay = 1'b1;
                end else begin
                        victimWay = !recentWay[curSet];   // Not recently used
                end
        end

        always_ff @(posedge CLK or posedge RESET) begin
                if (RESET) begin
                        validBits[0] <= '0;
                        validBits[1] <= '0;
                        recentWay    <= '0;
                end else if (refill) begin
                        validBits[victimWay][curSet] <= 1'b1;
                        recentWay[curSet]            <= victimWay;
                end else if (touch) begin
                        recentWay[curSet] <= hitWay;
                end
        end

        // Tag and data payload
        always_ff @(posedge CLK) begin
                if (refill) begin
                        tagMem[victimWay][curSet]  <= curTag;
                        dataMem[victimWay][curSet] <= refillData;
                end
        end

endmodule

/* src/fetchCache.sv */
// Instruction fetch subsystem top with cache, refill FSM, timer, memory and stats
`timescale 1ns/1ps

module fetchCache (
        input  logic                     CLK,
        input  logic                     RESET,
        input  logic                     fetchReq,
        input  fetchCachePkg::addrT      fetchAddr,
        input  logic                     loadEn,
        input  fetchCachePkg::memAddrT   loadAddr,
        input  fetchCachePkg::wordT      loadData,
        output logic                     busy,
        output logic                     fetchValid,
        output logic                     fetchHit,
        output fetchCachePkg::wordT      fetchData,
        output fetchCachePkg::statCountT hitCount,
        output fetchCachePkg::statCountT missCount
);
        import fetchCachePkg::*;

        tagT     curTag;
        setT     curSet;
        memAddrT memAddr;
        wordT    lookupData;
        wordT    memData;
        logic    lookupHit;
        logic    touch;
        logic    refill;
        logic    timerStart;
        logic    timerDone;
        logic    countHit;
        logic    countMiss;

        refillController controller (
                .CLK        (CLK),
                .RESET      (RESET),
                .fetchReq   (fetchReq),
                .fetchAddr  (fetchAddr),
                .lookupHit  (lookupHit),
                .lookupData (lookupData),
                .timerDone  (timerDone),
                .memData    (memData),
                .curTag     (curTag),
                .curSet     (curSet),
                .memAddr    (memAddr),
                .touch      (touch),
                .refill     (refill),
                .timerStart (timerStart),
                .countHit   (countHit),
                .countMiss  (countMiss),
                .busy       (busy),
                .fetchValid (fetchValid),
                .fetchHit   (fetchHit),
                .fetchData  (fetchData)
        );

        cacheWayArray wayArray (
                .CLK        (CLK),
                .RESET      (RESET),
                .curTag     (curTag),
                .curSet     (curSet),
                .touch      (touch),
                .refill     (refill),
                .refillData (memData),
                .lookupHit  (lookupHit),
                .lookupData (lookupData)
        );

        missLatencyTimer latencyTimer (
                .CLK   (CLK),
                .RESET (RESET),
                .start (timerStart),
                .done  (timerDone)
        );

        // Read address follows the captured request
        mainMemory memory (
                .CLK      (CLK),
                .loadEn   (loadEn),
                .loadAddr (loadAddr),
                .loadData (loadData),
                .readAddr (memAddr),
                .readData (memData)
        );

        accessStats stats (
                .CLK       (CLK),
                .RESET     (RESET),
                .countHit  (countHit),
                .countMiss (countMiss),
                .hitCount  (hitCount),
                .missCount (missCount)
        );

endmodule

/* src/fetchCachePkg.sv */
// Fetch cache vector types and refill controller state enum
`include "fetchCache_config.svh"

package fetchCachePkg;

        typedef logic [31:0] addrT;                          // Fetch byte address
        typedef logic [31:0] wordT;                          // Instruction word
        typedef logic [27:0] tagT;                           // Address bits 31:4
        typedef logic [`FC_SET_BITS-1:0] setT;               // Address bits 3:2
        typedef logic [$clog2(`FC_MEM_WORDS)-1:0] memAddrT;  // Address bits 9:2

        // Hit and miss counters wrap at overflow
        typedef logic [19:0] statCountT;

        typedef enum logic [1:0] {
                IDLE,
                LOOKUP,
                REFILL,
                RESPOND
        } refillStateT;

endpackage

/* src/fetchCache_config.svh */
// Fetch cache geometry, main memory depth and main memory latency
`ifndef FETCHCACHE_CONFIG_SVH
`define FETCHCACHE_CONFIG_SVH

// Cache geometry
`define FC_SETS 4
`define FC_SET_BITS 2

// Word-addressed main memory behind the cache
`define FC_MEM_WORDS 256

// Cycles from timer start until the memory word is usable
`define FC_MEM_LATENCY 3

`endif

/* src/mainMemory.sv */
// Word-addressed main memory with load port and registered read
`timescale 1ns/1ps
`include "fetchCache_config.svh"

module mainMemory (
        input  logic                   CLK,
        input  logic                   loadEn,
        input  fetchCachePkg::memAddrT loadAddr,
        input  fetchCachePkg::wordT    loadData,
        input  fetchCachePkg::memAddrT readAddr,
        output fetchCachePkg::wordT    readData
);
        import fetchCachePkg::*;

        wordT memArray [`FC_MEM_WORDS];

        always_ff @(posedge CLK) begin
                if (loadEn) begin
                        memArray[loadAddr] <= loadData;
                end
                readData <= memArray[readAddr];   // Read every cycle
        end

endmodule

/* src/missLatencyTimer.sv */
// Down counter for the main memory access latency
`timescale 1ns/1ps
`include "fetchCache_config.svh"

module missLatencyTimer (
        input  logic CLK,
        input  logic RESET,
        input  logic start,
        output logic done
);
        localparam int countBits = $clog2(`FC_MEM_LATENCY + 1);

        logic [countBits-1:0] count;   // Zero while idle

        always_ff @(posedge CLK or posedge RESET) begin
                if (RESET) begin
                        count <= '0;
                        done  <= 1'b0;
                end else begin
                        done <= (count == 1);   // Pulse as the count reaches zero
                        if (start) begin
                                count <= countBits'(`FC_MEM_LATENCY);
                        end else if (count != 0) begin
                                count <= count - 1'b1;
                        end
                end
        end

endmodule

/* src/refillController.sv */
// Fetch request FSM for lookup, miss refill and response
`timescale 1ns/1ps

module refillController (
        input  logic                   CLK,
        input  logic                   RESET,
        input  logic                   fetchReq,
        input  fetchCachePkg::addrT    fetchAddr,
        input  logic                   lookupHit,
        input  fetchCachePkg::wordT    lookupData,
        input  logic                   timerDone,
        input  fetchCachePkg::wordT    memData,
        output fetchCachePkg::tagT     curTag,
        output fetchCachePkg::setT     curSet,
        output fetchCachePkg::memAddrT memAddr,
        output logic                   touch,
        output logic                   refill,
        output logic                   timerStart,
        output logic                   countHit,
        output logic                   countMiss,
        output logic                   busy,
        output logic                   fetchValid,
        output logic                   fetchHit,
        output fetchCachePkg::wordT    fetchData
);
        import fetchCachePkg::*;

        refillStateT state;
        refillStateT nextState;
        addrT        capAddr;    // Address of the request in flight

        assign curTag  = capAddr[31:4];
        assign curSet  = capAddr[3:2];
        assign memAddr = capAddr[9:2];

        // Strobes decoded from the current state
        assign touch      = (state == LOOKUP) && lookupHit;
        assign countHit   = touch;
        assign countMiss  = (state == LOOKUP) && !lookupHit;
        assign timerStart = countMiss;
        assign refill     = (state == REFILL) && timerDone;

        assign busy = (state != IDLE);

        always_comb begin
                nextState = state;
                case (state)
                        IDLE:    if (fetchReq) nextState = LOOKUP;
                        LOOKUP:  nextState = lookupHit ? RESPOND : REFILL;
                        REFILL:  if (timerDone) nextState = RESPOND;
                        RESPOND: nextState = IDLE;
                        default: nextState = IDLE;
                endcase
        end

        always_ff @(posedge CLK or posedge RESET) begin
                if (RESET) begin
                        state      <= IDLE;
                        fetchValid <= 1'b0;
                end else begin
                        state      <= nextState;
                        fetchValid <= touch || refill;   // High for the RESPOND cycle
                end
        end

        // Request address and response payload
        always_ff @(posedge CLK) begin
                if ((state == IDLE) && fetchReq) begin
                        capAddr <= fetchAddr;
                end
                if (touch) begin
                        fetchHit  <= 1'b1;
                        fetchData <= lookupData;
                end else if (refill) begin
                        fetchHit  <= 1'b0;
                        fetchData <= memData;   // Same word goes into the victim way
                end
        end

endmodule

/* tb/fetchCacheTb.sv */
// Testbench for the fetch cache with memory preload, directed tests and reference model
`timescale 1ns/1ps
`include "fetchCache_config.svh"

module fetchCacheTb;
        import fetchCachePkg::*;

        logic      CLK;
        logic      RESET;
        logic      fetchReq;
        addrT      fetchAddr;
        logic      loadEn;
        memAddrT   loadAddr;
        wordT      loadData;
        logic      busy;
        logic      fetchValid;
        logic      fetchHit;
        wordT      fetchData;
        statCountT hitCount;
        statCountT missCount;

        wordT   memModel [`FC_MEM_WORDS];
        tagT    refTag [2][`FC_SETS];     // Reference cache state
        logic   refValid [2][`FC_SETS];
        logic   refRecent [`FC_SETS];
        int     expHits;
        int     expMisses;
        integer seed;

        fetchCache fetchCache_inst (.*);

        always #2 CLK = ~CLK;

        function automatic wordT fillWord(input memAddrT a);
                return {a, ~a, a ^ 8'h5a, a + 8'h31};
        endfunction

        task automatic failRun();
                $display(">>> FAIL");
                $fatal(1, "stopping at first error");
        endtask

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
                assert (got === exp) else begin
                        $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
                        failRun();
                end
        endtask

        task automatic loadMemory();
                for (int i = 0; i < `FC_MEM_WORDS; i++) begin
                        @(posedge CLK);
                        loadEn   <= 1'b1;
                        loadAddr <= memAddrT'(i);
                        loadData <= fillWord(memAddrT'(i));
                        memModel[i] = fillWord(memAddrT'(i));
                end
                @(posedge CLK);
                loadEn <= 1'b0;
        endtask

        // wantHit 0 or 1 is a directed expectation, 2 leaves it to the model
        task automatic fetchCheck(input addrT a, input bit extraReq, input int wantHit);
                int   cycles;
                int   expCycles;
                setT  s;
                logic expHit;
                logic way;
                s      = a[3:2];
                expHit = 1'b0;
                way    = 1'b0;
                if (refValid[0][s] && refTag[0][s] == a[31:4]) begin
                        expHit = 1'b1;
                end else if (refValid[1][s] && refTag[1][s] == a[31:4]) begin
                        expHit = 1'b1;
                        way    = 1'b1;
                end else if (!refValid[0][s]) way = 1'b0;
                else if (!refValid[1][s]) way = 1'b1;
                else way = !refRecent[s];   // Not recently used way is the victim
                if (wantHit != 2) begin
                        checkValue("reference hit", expHit, wantHit);
                end
                expCycles = expHit ? 2 : 3 + `FC_MEM_LATENCY;
                @(posedge CLK);
                fetchReq  <= 1'b1;
                fetchAddr <= a;
                cycles = 0;
                forever begin
                        @(posedge CLK);
                        fetchReq <= extraReq && (cycles == 1);   // Strobe while busy
                        if (extraReq && (cycles == 1)) begin
                                fetchAddr <= a ^ 32'h0000_0040;   // Other tag, same set
                        end
                        @(negedge CLK);
                        cycles++;
                        checkValue("busy", busy, 1'b1);
                        if (fetchValid) break;
                        if (cycles > 40) begin
                                $display("Timeout waiting for fetchValid at address 0x%0h", a);
                                failRun();
                        end
                end
                if (expHit) begin
                        expHits++;
                        refRecent[s] = way;
                end else begin
                        expMisses++;
                        refTag[way][s]   = a[31:4];
                        refValid[way][s] = 1'b1;
                        refRecent[s]     = way;
                end
                checkValue("fetchHit", fetchHit, expHit);
                checkValue("fetchData", fetchData, memModel[a[9:2]]);
                checkValue("cycles", cycles, expCycles);
                checkValue("hitCount", hitCount, expHits);
                checkValue("missCount", missCount, expMisses);
                @(posedge CLK);
                fetchReq <= 1'b0;
                @(negedge CLK);
                checkValue("busy", busy, 1'b0);   // Idle once the pulse has ended
        endtask

        task automatic coldAndRepeat();
                fetchCheck(32'h0000_0100, 1'b0, 0);
                fetchCheck(32'h0000_0100, 1'b0, 1);
        endtask

        task automatic bothWaysHold();
                fetchCheck(32'h0000_0200, 1'b0, 0);    // Same set 0, new tag
                fetchCheck(32'h0000_0100, 1'b0, 1);
                fetchCheck(32'h0000_0200, 1'b0, 1);
        endtask

        task automatic replaceLru();
                fetchCheck(32'h0000_0014, 1'b0, 0);    // Way A
                fetchCheck(32'h0000_0024, 1'b0, 0);    // Way B
                fetchCheck(32'h0000_0014, 1'b0, 1);    // Touch A
                fetchCheck(32'h0000_0034, 1'b0, 0);    // Evicts B
                fetchCheck(32'h0000_0014, 1'b0, 1);
                fetchCheck(32'h0000_0024, 1'b0, 0);
        endtask

        task automatic ignoreBusyReq();
                fetchCheck(32'h0000_0308, 1'b1, 0);
                fetchCheck(32'h0000_0308, 1'b1, 1);
        endtask

        task automatic randomFetches();
                addrT a;
                for (int i = 0; i < 60; i++) begin
                        a = 32'h400 + ({$random(seed)} % 4) * 16 + ({$random(seed)} % 4) * 4;
                        fetchCheck(a, 1'b0, 2);
                end
        endtask

        initial begin
                CLK       = 1'b0;
                RESET     = 1'b1;
                fetchReq  = 1'b0;
                fetchAddr = '0;
                loadEn    = 1'b0;
                loadAddr  = '0;
                loadData  = '0;
                seed      = 41368;
                expHits   = 0;
                expMisses = 0;
                for (int s = 0; s < `FC_SETS; s++) begin
                        refValid[0][s] = 1'b0;
                        refValid[1][s] = 1'b0;
                        refRecent[s]   = 1'b0;
                end
                repeat (3) @(posedge CLK);
                RESET <= 1'b0;
                loadMemory();
                coldAndRepeat();
                bothWaysHold();
                replaceLru();
                ignoreBusyReq();
                randomFetches();
                $display(">>> PASS");
                $finish;
        end

endmodule

/* tb/fetchCache_chk.sv */
// Bound assertions on the fetch cache top level handshake and counters
`timescale 1ns/1ps

module fetchCache_chk (
        input logic                     CLK,
        input logic                     RESET,
        input logic                     fetchReq,
        input logic                     busy,
        input logic                     fetchValid,
        input fetchCachePkg::statCountT hitCount,
        input fetchCachePkg::statCountT missCount
);

        validOneCycle: assert property (@(posedge CLK) disable iff (RESET)
                fetchValid |=> !fetchValid)
                else $error("fetchValid stayed high for more than one cycle");

        validWhileBusy: assert property (@(posedge CLK) disable iff (RESET)
                fetchValid |-> busy)
                else $error("fetchValid high while busy is low");

        // Busy rising marks the LOOKUP cycle, the only one that counts
        ignoredReqStats: assert property (@(posedge CLK) disable iff (RESET)
                (fetchReq && busy && !$rose(busy)) |=> ($stable(hitCount) && $stable(missCount)))
                else $error("request while busy changed the counters");

        idleAfterReset: assert property (@(posedge CLK)
                $fell(RESET) |-> !busy)
                else $error("busy high right after reset");

endmodule

bind fetchCache fetchCache_chk fetchCacheChecks (.*);
